// File: hdl/icache_pkg.sv
////////////////////
// geometry, address split and controller states of the instruction cache
// imported by every cache module and by the testbench
////////////////////

`default_nettype none

package icache_pkg;

  ////////////////////
  // word and address widths

  // physical fetch address
  localparam int unsigned addr_width     = 32;
  // one instruction word
  localparam int unsigned fetch_width    = 32;

  ////////////////////
  // cache geometry

  // four ways per set
  localparam int unsigned num_ways       = 4;
  localparam int unsigned way_width      = $clog2(num_ways);
  // lines held by each way
  localparam int unsigned num_sets       = 16;
  localparam int unsigned index_width    = $clog2(num_sets);
  // a line is refilled in a single beat
  localparam int unsigned line_width     = 128;
  localparam int unsigned words_per_line = line_width / fetch_width;
  // byte offset inside a line
  localparam int unsigned offset_width   = $clog2(line_width / 8);
  // whatever remains above index and offset
  localparam int unsigned tag_width      = addr_width - index_width - offset_width;

  ////////////////////
  // replacement

  // random way pick once a set is full
  localparam int unsigned  lfsr_width = 8;
  // any nonzero start value works
  localparam logic [7:0]   lfsr_seed  = 8'hA5;

  // controller states
  // FLUSH clears valid bits, IDLE waits for a fetch,
  // READ does the tag compare, MISS waits for the refill beat
  typedef enum logic [1:0] {
    FLUSH = 2'b00,
    IDLE  = 2'b01,
    READ  = 2'b10,
    MISS  = 2'b11
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/icache_req_decode.sv
////////////////////
// fetch address latch and tag/index/offset split
////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_req_decode import icache_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // fetch accepted this cycle
  input  logic                               accept_i,
  input  logic [addr_width-1:0]              addr_i,
  output logic [tag_width-1:0]               tag_o,
  output logic [index_width-1:0]             index_o,
  output logic [$clog2(words_per_line)-1:0]  word_o,
  // line aligned refill address
  output logic [addr_width-1:0]              line_addr_o
);

  // fetches are word aligned, the low two bits are dropped
  logic [addr_width-1:2] addr_q;

  // latched on acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_addr
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (accept_i) begin
      addr_q <= addr_i[addr_width-1:2];
    end
  end

  // set index, taken straight from the port while accepting
  // so the arrays can be read in the acceptance cycle
  assign index_o = accept_i ? addr_i[offset_width +: index_width]
                            : addr_q[offset_width +: index_width];

  // tag for the compare in the following cycle, and for the refill write
  assign tag_o = addr_q[addr_width-1 -: tag_width];

  // word inside the line
  assign word_o = addr_q[offset_width-1:2];

  // refill requests always cover a whole line
  assign line_addr_o = {addr_q[addr_width-1:offset_width], {offset_width{1'b0}}};

endmodule

`default_nettype wire

// File: hdl/icache_ctrl.sv
////////////////////
// cache controller FSM with flush counter and memory request
////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // fetch side
  input  logic                    req_i,
  input  logic                    flush_i,
  input  logic                    hit_i,
  output logic                    ready_o,
  output logic                    valid_o,
  // performance counter
  output logic                    miss_o,
  // memory side
  input  logic                    mem_ack_i,
  input  logic                    mem_rtrn_vld_i,
  output logic                    mem_req_o,
  // array control
  output logic                    rden_o,
  output logic                    wren_o,
  output logic                    flush_en_o,
  output logic [index_width-1:0]  flush_idx_o,
  output ctrl_state_e             state_o
);

  ctrl_state_e            state_d, state_q;
  logic                   flush_d, flush_q;
  logic [index_width-1:0] flush_cnt_d, flush_cnt_q;
  logic                   flush_done;

  ////////////////////
  // flush counter

  // one set per cycle, last set ends the flush
  assign flush_done  = (flush_cnt_q == index_width'(num_sets - 1));
  assign flush_cnt_d = !flush_en_o ? flush_cnt_q :
                       flush_done  ? '0          :
                                     flush_cnt_q + 1'b1;
  assign flush_idx_o = flush_cnt_q;

  ////////////////////
  // next state

  always_comb begin : p_fsm
    state_d    = state_q;
    // a flush request waits here until it can be taken
    flush_d    = flush_q | flush_i;
    flush_en_o = 1'b0;
    rden_o     = 1'b0;
    wren_o     = 1'b0;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    mem_req_o  = 1'b0;
    miss_o     = 1'b0;

    unique case (state_q)
      // clear valid bits, also after reset
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      // pending flush goes first, else accept a fetch
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            rden_o  = 1'b1;
            state_d = READ;
          end
        end
      end
      // arrays are valid now, compare result decides
      READ: begin
        if (hit_i) begin
          valid_o = 1'b1;
          state_d = IDLE;
          if (flush_d) begin
            state_d = FLUSH;
          end else begin
            // back to back hits
            ready_o = 1'b1;
            if (req_i) begin
              rden_o  = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          // hold the line request until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = MISS;
          end
        end
      end
      // refill beat returns the word and fills the line
      MISS: begin
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          wren_o  = 1'b1;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

// File: hdl/icache_arrays.sv
////////////////////
// tag, valid and data storage per way, plus random replacement
////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_arrays import icache_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // lookup and refill
  input  logic                                 rden_i,
  input  logic                                 wren_i,
  // clear one set per cycle
  input  logic                                 flush_en_i,
  input  logic [index_width-1:0]               flush_idx_i,
  input  logic [index_width-1:0]               index_i,
  input  logic [tag_width-1:0]                 tag_i,
  input  logic [line_width-1:0]                line_i,
  // read data, one cycle after rden_i
  output logic [num_ways-1:0][tag_width-1:0]   tag_o,
  output logic [num_ways-1:0]                  valid_o,
  output logic [num_ways-1:0][line_width-1:0]  line_o
);

  logic [tag_width-1:0]   tag_mem  [num_ways][num_sets];
  logic [line_width-1:0]  data_mem [num_ways][num_sets];
  logic [num_sets-1:0][num_ways-1:0] valid_q;

  logic [way_width-1:0]   inv_way;
  logic                   all_valid;
  logic [way_width-1:0]   repl_way_q;
  logic                   full_q;
  logic [lfsr_width-1:0]  lfsr_q;
  logic                   lfsr_fb;

  ////////////////////
  // storage

  // synchronous read of every way
  always_ff @(posedge clk_i) begin : p_read
    if (rden_i) begin
      for (int w = 0; w < num_ways; w++) begin
        tag_o[w]  <= tag_mem[w][index_i];
        line_o[w] <= data_mem[w][index_i];
      end
    end
  end

  // refill goes only into the chosen way
  always_ff @(posedge clk_i) begin : p_write
    if (wren_i) begin
      tag_mem[repl_way_q][index_i]  <= tag_i;
      data_mem[repl_way_q][index_i] <= line_i;
    end
  end

  // valid bits are cleared by reset and by the flush
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      valid_q <= '0;
      valid_o <= '0;
    end else begin
      if (flush_en_i) begin
        valid_q[flush_idx_i] <= '0;
      end else if (wren_i) begin
        valid_q[index_i][repl_way_q] <= 1'b1;
      end
      if (rden_i) begin
        valid_o <= valid_q[index_i];
      end
    end
  end

  ////////////////////
  // replacement

  // lowest way that is still empty
  always_comb begin : p_inv_way
    inv_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!valid_q[index_i][w]) begin
        inv_way = way_width'(w);
      end
    end
  end

  assign all_valid = &valid_q[index_i];

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // victim is fixed at lookup time and kept until the refill
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_repl
    if (!rst_ni) begin
      repl_way_q <= '0;
      full_q     <= 1'b0;
      lfsr_q     <= lfsr_seed;
    end else begin
      if (rden_i) begin
        repl_way_q <= all_valid ? lfsr_q[way_width-1:0] : inv_way;
        full_q     <= all_valid;
      end
      // only a write into a full set uses up a random pick
      if (wren_i && full_q) begin
        lfsr_q <= {lfsr_q[lfsr_width-2:0], lfsr_fb};
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_hit_select.sv
////////////////////
// tag compare, hit way and output word select
////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_hit_select import icache_pkg::*; (
  input  ctrl_state_e                          state_i,
  // latched request fields
  input  logic [tag_width-1:0]                 tag_i,
  input  logic [$clog2(words_per_line)-1:0]    word_i,
  // array read data
  input  logic [num_ways-1:0][tag_width-1:0]   tag_rd_i,
  input  logic [num_ways-1:0]                  valid_rd_i,
  input  logic [num_ways-1:0][line_width-1:0]  line_rd_i,
  // refill line from memory
  input  logic [line_width-1:0]                rtrn_line_i,
  output logic                                 hit_o,
  output logic [fetch_width-1:0]               data_o
);

  typedef logic [way_width-1:0] way_t;

  logic [num_ways-1:0]                   hit_vec;
  logic [num_ways-1:0][fetch_width-1:0]  way_word;
  logic [way_width-1:0]                  hit_way;

  // compare each way and pick the requested word from its line
  for (genvar w = 0; w < num_ways; w++) begin : gen_cmp
    assign hit_vec[w]  = valid_rd_i[w] && (tag_rd_i[w] == tag_i);
    assign way_word[w] = line_rd_i[w][word_i*fetch_width +: fetch_width];
  end

  assign hit_o = |hit_vec;

  // at most one way hits, lowest one wins anyway
  always_comb begin : p_hit_way
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  // refill data bypasses the arrays during a miss
  always_comb begin : p_data
    if (state_i == MISS) begin
      data_o = rtrn_line_i[word_i*fetch_width +: fetch_width];
    end else begin
      data_o = way_word[hit_way];
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
////////////////////
// four way instruction cache, fetch port and single beat line refill port
////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // fetch side
  input  logic                    req_i,
  input  logic [addr_width-1:0]   addr_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output logic [fetch_width-1:0]  data_o,
  // flush and performance counter
  input  logic                    flush_i,
  output logic                    miss_o,
  // memory side
  output logic                    mem_req_o,
  output logic [addr_width-1:0]   mem_addr_o,
  input  logic                    mem_ack_i,
  input  logic                    mem_rtrn_vld_i,
  input  logic [line_width-1:0]   mem_rtrn_data_i
);

  logic                                 accept;
  logic [tag_width-1:0]                 tag;
  logic [index_width-1:0]               index;
  logic [$clog2(words_per_line)-1:0]    word;
  logic                                 hit;
  logic                                 rden;
  logic                                 wren;
  logic                                 flush_en;
  logic [index_width-1:0]               flush_idx;
  ctrl_state_e                          state;
  logic [num_ways-1:0][tag_width-1:0]   tag_rd;
  logic [num_ways-1:0]                  valid_rd;
  logic [num_ways-1:0][line_width-1:0]  line_rd;

  // fetch handshake
  assign accept = ready_o & req_i;

  icache_req_decode u_req_decode (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .accept_i    ( accept     ),
    .addr_i      ( addr_i     ),
    .tag_o       ( tag        ),
    .index_o     ( index      ),
    .word_o      ( word       ),
    .line_addr_o ( mem_addr_o )
  );

  icache_ctrl u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .flush_i        ( flush_i        ),
    .hit_i          ( hit            ),
    .ready_o        ( ready_o        ),
    .valid_o        ( valid_o        ),
    .miss_o         ( miss_o         ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .mem_req_o      ( mem_req_o      ),
    .rden_o         ( rden           ),
    .wren_o         ( wren           ),
    .flush_en_o     ( flush_en       ),
    .flush_idx_o    ( flush_idx      ),
    .state_o        ( state          )
  );

  // refill line is written straight from the memory port
  icache_arrays u_arrays (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .rden_i      ( rden            ),
    .wren_i      ( wren            ),
    .flush_en_i  ( flush_en        ),
    .flush_idx_i ( flush_idx       ),
    .index_i     ( index           ),
    .tag_i       ( tag             ),
    .line_i      ( mem_rtrn_data_i ),
    .tag_o       ( tag_rd          ),
    .valid_o     ( valid_rd        ),
    .line_o      ( line_rd         )
  );

  icache_hit_select u_hit_select (
    .state_i     ( state           ),
    .tag_i       ( tag             ),
    .word_i      ( word            ),
    .tag_rd_i    ( tag_rd          ),
    .valid_rd_i  ( valid_rd        ),
    .line_rd_i   ( line_rd         ),
    .rtrn_line_i ( mem_rtrn_data_i ),
    .hit_o       ( hit             ),
    .data_o      ( data_o          )
  );

endmodule

`default_nettype wire

// File: sim/icache_sva.sv
////////////////////
// protocol checks on the fetch and memory ports, bound into the cache top level
////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_sva import icache_pkg::*; (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_i,
  input logic                   ready_o,
  input logic                   valid_o,
  input logic                   mem_req_o,
  input logic [addr_width-1:0]  mem_addr_o,
  input logic                   mem_ack_i
);

  // number of failed properties so far
  int unsigned fail_cnt = 0;
  logic        pending_q;

  // a fetch is open from acceptance until its valid_o
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pending
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (req_i && ready_o) begin
      pending_q <= 1'b1;
    end else if (valid_o) begin
      pending_q <= 1'b0;
    end
  end

  // line request stays put until memory acks it
  a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
      fail_cnt++;
      $error("mem_req_o or mem_addr_o changed before mem_ack_i");
    end

  // every word answers an accepted fetch
  a_valid_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> pending_q)
    else begin
      fail_cnt++;
      $error("valid_o without an outstanding fetch");
    end

endmodule

bind icache_top icache_sva u_icache_sva (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .req_i      ( req_i      ),
  .ready_o    ( ready_o    ),
  .valid_o    ( valid_o    ),
  .mem_req_o  ( mem_req_o  ),
  .mem_addr_o ( mem_addr_o ),
  .mem_ack_i  ( mem_ack_i  )
);

`default_nettype wire

// File: sim/tb_icache.sv
////////////////////
// testbench for the instruction cache, runs fetches against a refill memory model
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

  // memory word at byte address a is a ^ mem_pattern
  localparam logic [fetch_width-1:0] mem_pattern = 32'h5a3c_96e1;
  localparam int unsigned            seed        = 32'h608e_0fc1;
  // about 1500 cycles expected for two flushes, 17 directed and 300 random fetches
  localparam int unsigned            max_cycles  = 4000;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    req_i;
  logic [addr_width-1:0]   addr_i;
  logic                    ready_o;
  logic                    valid_o;
  logic [fetch_width-1:0]  data_o;
  logic                    flush_i;
  logic                    miss_o;
  logic                    mem_req_o;
  logic [addr_width-1:0]   mem_addr_o;
  logic                    mem_ack_i;
  logic                    mem_rtrn_vld_i;
  logic [line_width-1:0]   mem_rtrn_data_i;

  // accepted fetch addresses, oldest first
  logic [addr_width-1:0]   fetch_q[$];
  logic                    accepted_q;
  logic                    expect_hit;
  int unsigned             miss_cnt;
  int unsigned             cycle_cnt;

  icache_top u_icache_top (.*);

  ////////////////////
  // reference model and failure reporting

  function automatic logic [fetch_width-1:0] expected_word(input logic [addr_width-1:0] addr);
    logic [addr_width-1:0] line;
    line = {addr[addr_width-1:offset_width], {offset_width{1'b0}}};
    return (line + 4 * addr[offset_width-1:2]) ^ mem_pattern;
  endfunction

  function automatic logic [line_width-1:0] line_data(input logic [addr_width-1:0] line);
    logic [line_width-1:0] data;
    for (int k = 0; k < words_per_line; k++) begin
      data[k*fetch_width +: fetch_width] = (line + 4 * k) ^ mem_pattern;
    end
    return data;
  endfunction

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [line_width-1:0] got,
                                 input logic [line_width-1:0] exp);
    $display("** Error %s got 0x%0h expected 0x%0h", name, got, exp);
    stop_run();
  endtask

  task automatic report_failure(input string what);
    $display("Error: %s", what);
    stop_run();
  endtask

  ////////////////////
  // clock, timeout, memory

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt >= max_cycles) begin
        report_failure($sformatf("timeout, run not finished after %0d cycles", max_cycles));
      end
    end
  end

  // ack and return beat each after 0 to 5 cycles
  initial begin : mem_model
    logic [addr_width-1:0] line;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (mem_req_o) begin
        assert (fetch_q.size() != 0)
          else report_failure("mem_req_o without an outstanding fetch");
        // refill must ask for the line of the missing fetch
        line = {fetch_q[0][addr_width-1:offset_width], {offset_width{1'b0}}};
        assert (mem_addr_o == line) else report_mismatch("mem_addr_o", mem_addr_o, line);
        repeat ($urandom % 6) @(negedge clk_i);
        mem_ack_i = 1'b1;
        @(negedge clk_i);
        mem_ack_i = 1'b0;
        repeat ($urandom % 6) @(negedge clk_i);
        mem_rtrn_vld_i  = 1'b1;
        mem_rtrn_data_i = line_data(line);
        @(negedge clk_i);
        mem_rtrn_vld_i  = 1'b0;
      end
    end
  end

  ////////////////////
  // scoreboard, samples once all inputs have settled

  always @(negedge clk_i) begin : monitor
    logic [fetch_width-1:0] exp;
    #1;
    assert (u_icache_top.u_icache_sva.fail_cnt == 0)
      else report_failure("a protocol assertion on the cache ports failed");
    if (valid_o) begin
      assert (fetch_q.size() != 0) else report_failure("valid_o without an outstanding fetch");
      exp = expected_word(fetch_q.pop_front());
      assert (data_o == exp) else report_mismatch("data_o", data_o, exp);
    end
    // cached lines answer in the cycle after acceptance
    if (expect_hit && accepted_q) begin
      assert (valid_o) else report_failure("hit did not raise valid_o one cycle after acceptance");
    end
    if (expect_hit) begin
      assert (!mem_req_o) else report_failure("mem_req_o rose for a cached line");
    end
    if (miss_o) begin
      miss_cnt++;
    end
    accepted_q = req_i && ready_o;
    if (accepted_q) begin
      fetch_q.push_back(addr_i);
    end
  end

  ////////////////////
  // stimulus

  // holds the request until it is taken, returns on the next falling edge
  task automatic fetch(input logic [addr_width-1:0] addr);
    req_i  = 1'b1;
    addr_i = addr;
    #1;
    while (!ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic drain();
    while (fetch_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  initial begin : stimulus
    logic [addr_width-1:0] set_lines[6];
    int unsigned           order[6];
    int unsigned           m0;
    int unsigned           j;
    int unsigned           tmp;
    void'($urandom(seed));
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    addr_i     = '0;
    flush_i    = 1'b0;
    expect_hit = 1'b0;
    accepted_q = 1'b0;
    miss_cnt   = 0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    // reset flush keeps every strobe low
    for (int i = 0; i < num_sets; i++) begin
      #1;
      assert (!ready_o && !valid_o && !mem_req_o && !miss_o)
        else report_failure("outputs not low during the reset flush");
      @(negedge clk_i);
    end
    #1;
    assert (ready_o) else report_failure("ready_o still low after the reset flush");
    @(negedge clk_i);

    // cold miss, then the rest of the line back to back
    m0 = miss_cnt;
    fetch(32'h0000_1004);
    drain();
    assert (miss_cnt == m0 + 1) else report_mismatch("miss_o count", miss_cnt, m0 + 1);
    expect_hit = 1'b1;
    fetch(32'h0000_1000);
    fetch(32'h0000_1008);
    fetch(32'h0000_100c);
    drain();
    expect_hit = 1'b0;

    // flush drops the cached line
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    m0 = miss_cnt;
    fetch(32'h0000_1008);
    drain();
    assert (miss_cnt == m0 + 1) else report_mismatch("miss_o count", miss_cnt, m0 + 1);

    // six lines in set 3, more than the ways hold
    for (int i = 0; i < 6; i++) begin
      set_lines[i] = 32'h0000_2030 + i * 32'h100;
      order[i]     = i;
      fetch(set_lines[i] + 4 * (i % 4));
    end
    for (int i = 5; i > 0; i--) begin
      j        = $urandom % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 6; i++) begin
      fetch(set_lines[order[i]] + 4 * ($urandom % 4));
    end
    drain();

    // random stream over 64 lines
    repeat (300) begin
      fetch(32'h0004_0000 + ($urandom % 64) * 16 + ($urandom % 4) * 4);
    end
    drain();

    if (u_icache_top.u_icache_sva.fail_cnt != 0) begin
      report_failure("a protocol assertion on the cache ports failed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: all.f
hdl/icache_pkg.sv
hdl/icache_req_decode.sv
hdl/icache_ctrl.sv
hdl/icache_arrays.sv
hdl/icache_hit_select.sv
hdl/icache_top.sv
sim/icache_sva.sv
sim/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - hdl/icache_pkg.sv
  - hdl/icache_req_decode.sv
  - hdl/icache_ctrl.sv
  - hdl/icache_arrays.sv
  - hdl/icache_hit_select.sv
  - hdl/icache_top.sv
  - target: simulation
    files:
      - sim/icache_sva.sv
      - sim/tb_icache.sv
